//--- sim.f
logic/btb_pkg.sv
logic/btb_ctrl_if.sv
logic/btb_array.sv
logic/btb_csr.sv
logic/btb_top.sv
dv/btb_tb.sv

//--- dv/btb_tb.sv
// btb testbench with table-driven lookups, updates and APB accesses against a reference model.
`default_nettype none

module btb_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import btb_pkg::*;

    localparam int SETS       = 16;
    localparam int WAIT_LIMIT = 200;

    // a pair in set 5 and a group in set 3 share an index with different tags.
    localparam addr_t PC_P = 32'h0000_0814;
    localparam addr_t PC_Q = 32'h0001_0814;
    localparam addr_t PC_A = 32'h0000_100C;
    localparam addr_t PC_B = 32'h0000_200C;
    localparam addr_t PC_C = 32'h0000_300C;
    localparam addr_t PC_D = 32'h0000_400C;

    typedef enum {OP_LOOKUP, OP_UPDATE, OP_WRITE, OP_READ, OP_WAIT} op_e;

    typedef struct {
        op_e         op;
        addr_t       addr;
        logic [31:0] value;
        logic        exp_hit;
    } step_t;

    logic        CLK = 1'b0;
    logic        rst;
    logic        branch;
    addr_t       pc;
    logic        pred_valid;
    logic        pred_hit;
    addr_t       pred_target;
    logic        upd_valid;
    addr_t       upd_pc;
    addr_t       upd_target;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;
    logic        ready;

    step_t       steps [$];
    logic [31:0] lfsr_state;

    // reference model state.
    logic             m_valid [SETS][2];
    logic [25:0]      m_tag   [SETS][2];
    addr_t            m_tgt   [SETS][2];
    logic             m_lru   [SETS];
    logic             m_enable;
    logic             m_busy;
    logic [CNT_W-1:0] m_hits;
    logic [CNT_W-1:0] m_misses;
    logic [CNT_W-1:0] m_updates;

    always #4 CLK = ~CLK;

    btb_top #(
        .NUM_SETS (SETS)
    ) DUT (.*);

    // ####################################################################
    // failure, random source and reference model
    // ####################################################################

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per target bit.
    task automatic draw_target(output addr_t t);
        t = '0;
        for (int i = 0; i < 32; i++) begin
            t          = {t[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] c);
        return (c == '1) ? c : c + 1'b1;
    endfunction

    task automatic model_flush();
        for (int s = 0; s < SETS; s++) begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        m_busy = 1'b1;
    endtask

    task automatic model_lookup(input addr_t p, output logic hit, output addr_t tgt);
        int          idx;
        logic [25:0] tag;
        idx = p[5:2];
        tag = p[31:6];
        hit = 1'b0;
        tgt = '0;
        if (!m_enable || m_busy) return;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                hit        = 1'b1;
                tgt        = m_tgt[idx][w];
                m_lru[idx] = (w == 0);
            end
        end
        if (hit) m_hits = sat_inc(m_hits);
        else m_misses = sat_inc(m_misses);
    endtask

    // matching tag first, then a free way from way 0 up, then the lru way.
    task automatic model_update(input addr_t p, input addr_t t);
        int          idx;
        int          way;
        logic [25:0] tag;
        idx = p[5:2];
        tag = p[31:6];
        way = -1;
        if (!m_enable || m_busy) return;
        for (int w = 0; w < 2; w++) begin
            if (way < 0 && m_valid[idx][w] && m_tag[idx][w] == tag) way = w;
        end
        for (int w = 0; w < 2; w++) begin
            if (way < 0 && !m_valid[idx][w]) way = w;
        end
        if (way < 0) way = m_lru[idx];
        m_valid[idx][way] = 1'b1;
        m_tag[idx][way]   = tag;
        m_tgt[idx][way]   = t;
        m_lru[idx]        = (way == 0);
        m_updates         = sat_inc(m_updates);
    endtask

    task automatic model_write(input logic [7:0] off, input logic [31:0] v);
        if (off == REG_CTRL) begin
            m_enable = v[0];
            if (v[2]) begin
                m_hits    = '0;
                m_misses  = '0;
                m_updates = '0;
            end
            if (v[1]) model_flush();
        end
    endtask

    task automatic model_read(input logic [7:0] off, output logic [31:0] d, output logic err);
        d   = '0;
        err = 1'b0;
        case (off)
            REG_CTRL:    d[0] = m_enable;
            REG_STATUS:  d[0] = m_busy;
            REG_HITS:    d = 32'(m_hits);
            REG_MISSES:  d = 32'(m_misses);
            REG_UPDATES: d = 32'(m_updates);
            default:     err = 1'b1;
        endcase
    endtask

    // ####################################################################
    // compare tasks
    // ####################################################################

    task automatic check_pred(input logic exp_hit, input addr_t exp_tgt);
        if (pred_valid !== 1'b1)
            abort_run($sformatf("FAILED at %0t: pred_valid expected 1, got %b",
                                $realtime, pred_valid));
        if (pred_hit !== exp_hit)
            abort_run($sformatf("FAILED at %0t: pred_hit expected %b, got %b",
                                $realtime, exp_hit, pred_hit));
        if (pred_target !== exp_tgt)
            abort_run($sformatf("FAILED at %0t: pred_target expected %h, got %h",
                                $realtime, exp_tgt, pred_target));
    endtask

    task automatic check_reg(input logic [31:0] exp_data, input logic exp_err);
        if (prdata !== exp_data)
            abort_run($sformatf("FAILED at %0t: prdata expected %h, got %h",
                                $realtime, exp_data, prdata));
        if (pslverr !== exp_err)
            abort_run($sformatf("FAILED at %0t: pslverr expected %b, got %b",
                                $realtime, exp_err, pslverr));
    endtask

    task automatic check_ready(input logic exp);
        if (ready !== exp)
            abort_run($sformatf("FAILED at %0t: ready expected %b, got %b",
                                $realtime, exp, ready));
    endtask

    // ####################################################################
    // drivers
    // ####################################################################

    task automatic do_lookup(input addr_t p, input logic exp_hit);
        logic  hit;
        addr_t tgt;
        model_lookup(p, hit, tgt);
        if (hit !== exp_hit)
            abort_run($sformatf("table expects hit %b for pc %h, reference model gives %b",
                                exp_hit, p, hit));
        @(posedge CLK);
        branch <= 1'b1;
        pc     <= p;
        @(posedge CLK);
        branch <= 1'b0;
        @(negedge CLK);
        check_pred(hit, tgt);
    endtask

    task automatic do_update(input addr_t p);
        addr_t t;
        draw_target(t);
        model_update(p, t);
        @(posedge CLK);
        upd_valid  <= 1'b1;
        upd_pc     <= p;
        upd_target <= t;
        @(posedge CLK);
        upd_valid  <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] off, input logic [31:0] v);
        model_write(off, v);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= off;
        pwdata  <= v;
        @(posedge CLK);
        penable <= 1'b1;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] off);
        logic [31:0] d;
        logic        err;
        model_read(off, d, err);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= off;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        check_reg(d, err);
        if (off == REG_STATUS) check_ready(!m_busy);
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_ready(input int limit);
        int n;
        n = 0;
        do begin
            @(negedge CLK);
            n++;
        end while (!ready && n < limit);
        if (!ready)
            abort_run($sformatf("ready did not rise within %0d cycles of waiting", limit));
        m_busy = 1'b0;
    endtask

    // ####################################################################
    // stimulus table
    // ####################################################################

    task automatic add_step(input op_e op, input addr_t a, input logic [31:0] v, input logic h);
        step_t s;
        s.op      = op;
        s.addr    = a;
        s.value   = v;
        s.exp_hit = h;
        steps.push_back(s);
    endtask

    task automatic build_table();
        // reset flush, then cold misses.
        add_step(OP_WAIT,   '0, '0, 1'b0);
        add_step(OP_LOOKUP, 32'h0000_0040, '0, 1'b0);
        add_step(OP_LOOKUP, 32'h1234_5678, '0, 1'b0);
        // store and retrieve plus a tag mismatch in the same set.
        add_step(OP_UPDATE, PC_P, '0, 1'b0);
        add_step(OP_LOOKUP, PC_P, '0, 1'b1);
        add_step(OP_LOOKUP, PC_Q, '0, 1'b0);
        // lru replacement in set 3.
        add_step(OP_UPDATE, PC_A, '0, 1'b0);
        add_step(OP_UPDATE, PC_B, '0, 1'b0);
        add_step(OP_LOOKUP, PC_A, '0, 1'b1);
        add_step(OP_UPDATE, PC_C, '0, 1'b0);
        add_step(OP_LOOKUP, PC_A, '0, 1'b1);
        add_step(OP_LOOKUP, PC_C, '0, 1'b1);
        add_step(OP_LOOKUP, PC_B, '0, 1'b0);
        // overwrite of an existing tag keeps the other way.
        add_step(OP_UPDATE, PC_A, '0, 1'b0);
        add_step(OP_LOOKUP, PC_A, '0, 1'b1);
        add_step(OP_LOOKUP, PC_C, '0, 1'b1);
        // counters after the traffic above.
        add_step(OP_READ,   32'(REG_HITS), '0, 1'b0);
        add_step(OP_READ,   32'(REG_MISSES), '0, 1'b0);
        add_step(OP_READ,   32'(REG_UPDATES), '0, 1'b0);
        // disabled buffer keeps its counts.
        add_step(OP_WRITE,  32'(REG_CTRL), 32'h0, 1'b0);
        add_step(OP_LOOKUP, PC_P, '0, 1'b0);
        add_step(OP_LOOKUP, PC_A, '0, 1'b0);
        add_step(OP_UPDATE, PC_D, '0, 1'b0);
        add_step(OP_READ,   32'(REG_HITS), '0, 1'b0);
        add_step(OP_READ,   32'(REG_MISSES), '0, 1'b0);
        add_step(OP_READ,   32'(REG_UPDATES), '0, 1'b0);
        // re-enable with a counter clear and an unmapped offset.
        add_step(OP_WRITE,  32'(REG_CTRL), 32'h5, 1'b0);
        add_step(OP_READ,   32'(REG_HITS), '0, 1'b0);
        add_step(OP_READ,   32'(REG_MISSES), '0, 1'b0);
        add_step(OP_READ,   32'(REG_UPDATES), '0, 1'b0);
        add_step(OP_READ,   32'h20, '0, 1'b0);
        add_step(OP_READ,   32'(REG_CTRL), '0, 1'b0);
        // the update made while disabled never landed.
        add_step(OP_LOOKUP, PC_D, '0, 1'b0);
        // flush wipes every entry.
        add_step(OP_WRITE,  32'(REG_CTRL), 32'h3, 1'b0);
        add_step(OP_READ,   32'(REG_STATUS), '0, 1'b0);
        add_step(OP_WAIT,   '0, '0, 1'b0);
        add_step(OP_READ,   32'(REG_STATUS), '0, 1'b0);
        add_step(OP_LOOKUP, PC_P, '0, 1'b0);
        add_step(OP_LOOKUP, PC_A, '0, 1'b0);
        add_step(OP_LOOKUP, PC_C, '0, 1'b0);
        add_step(OP_READ,   32'(REG_MISSES), '0, 1'b0);
    endtask

    initial begin
        step_t s;
        $timeformat(-9, 1, " ns", 0);
        rst        <= 1'b1;
        branch     <= 1'b0;
        pc         <= '0;
        upd_valid  <= 1'b0;
        upd_pc     <= '0;
        upd_target <= '0;
        psel       <= 1'b0;
        penable    <= 1'b0;
        pwrite     <= 1'b0;
        paddr      <= '0;
        pwdata     <= '0;
        lfsr_state = 32'h0731_4d91;
        m_enable   = 1'b1;
        m_hits     = '0;
        m_misses   = '0;
        m_updates  = '0;
        model_flush();
        build_table();
        repeat (8) @(posedge CLK);
        rst <= 1'b0;
        foreach (steps[i]) begin
            s = steps[i];
            case (s.op)
                OP_LOOKUP: do_lookup(s.addr, s.exp_hit);
                OP_UPDATE: do_update(s.addr);
                OP_WRITE:  apb_write(s.addr[7:0], s.value);
                OP_READ:   apb_read(s.addr[7:0]);
                default:   wait_ready(WAIT_LIMIT);
            endcase
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule : btb_tb

`default_nettype wire

//--- logic/btb_top.sv
// btb top level wiring the register block beside the target array.
`default_nettype none

module btb_top #(
    parameter int NUM_SETS = 256
) (
    input  logic           CLK,
    input  logic           rst,
    // fetch lookup.
    input  logic           branch,
    input  btb_pkg::addr_t pc,
    output logic           pred_valid,
    output logic           pred_hit,
    output btb_pkg::addr_t pred_target,
    // execute update.
    input  logic           upd_valid,
    input  btb_pkg::addr_t upd_pc,
    input  btb_pkg::addr_t upd_target,
    // APB.
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [7:0]     paddr,
    input  logic [31:0]    pwdata,
    output logic [31:0]    prdata,
    output logic           pslverr,
    // low while a flush walk runs.
    output logic           ready
);

    btb_ctrl_if ctrl_if ();

    // ####################################################################
    // register block
    // ####################################################################

    btb_csr u_csr (
        .CLK     (CLK),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .ctrl    (ctrl_if.csr)
    );

    // ####################################################################
    // target array
    // ####################################################################

    btb_array #(
        .NUM_SETS (NUM_SETS)
    ) u_array (
        .CLK         (CLK),
        .rst         (rst),
        .branch      (branch),
        .pc          (pc),
        .upd_valid   (upd_valid),
        .upd_pc      (upd_pc),
        .upd_target  (upd_target),
        .pred_valid  (pred_valid),
        .pred_hit    (pred_hit),
        .pred_target (pred_target),
        .ctrl        (ctrl_if.array)
    );

    assign ready = ~ctrl_if.flush_busy;

endmodule : btb_top

`default_nettype wire

//--- logic/btb_csr.sv
// btb register block with APB access to enable, flush, status and event counters.
`default_nettype none

module btb_csr (
    input  logic        CLK,
    input  logic        rst,
    // APB slave with zero wait states.
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    btb_ctrl_if.csr     ctrl
);
    import btb_pkg::*;

    localparam int NUM_CNT = 3;
    localparam int CNT_HIT = 0;
    localparam int CNT_MISS = 1;
    localparam int CNT_UPD = 2;

    csr_reg_e           reg_sel;
    logic               mapped;
    logic               access;
    logic               wr_en;
    logic               ctrl_wr;
    logic               cnt_clr;
    logic               enable_q;
    logic               flush_start_q;
    logic [NUM_CNT-1:0] evt;
    logic [CNT_W-1:0]   cnt_q [NUM_CNT];
    logic [31:0]        rd_data;

    // ####################################################################
    // address decode
    // ####################################################################

    assign reg_sel = csr_reg_e'(paddr);

    always_comb begin
        case (reg_sel)
            REG_CTRL, REG_STATUS, REG_HITS, REG_MISSES, REG_UPDATES: begin
                mapped = 1'b1;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign access  = psel && penable;
    assign wr_en   = access && pwrite && mapped;
    assign ctrl_wr = wr_en && (reg_sel == REG_CTRL);
    assign cnt_clr = ctrl_wr && pwdata[CTRL_CLEAR_BIT];

    // ####################################################################
    // control bits
    // ####################################################################

    // enable comes up set; flush_start is a one-cycle strobe.
    always_ff @(posedge CLK) begin
        if (rst) begin
            enable_q      <= 1'b1;
            flush_start_q <= 1'b0;
        end else begin
            flush_start_q <= ctrl_wr && pwdata[CTRL_FLUSH_BIT];
            if (ctrl_wr) begin
                enable_q <= pwdata[CTRL_ENABLE_BIT];
            end
        end
    end

    assign ctrl.enable      = enable_q;
    assign ctrl.flush_start = flush_start_q;

    // ####################################################################
    // event counters
    // ####################################################################

    assign evt[CNT_HIT]  = ctrl.hit_evt;
    assign evt[CNT_MISS] = ctrl.miss_evt;
    assign evt[CNT_UPD]  = ctrl.upd_evt;

    // clear beats a same-cycle event. counters stick at all ones.
    always_ff @(posedge CLK) begin
        if (rst || cnt_clr) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_CNT; i++) begin
                if (evt[i] && (cnt_q[i] != '1)) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    // ####################################################################
    // read path
    // ####################################################################

    always_comb begin
        rd_data = '0;
        case (reg_sel)
            REG_CTRL:    rd_data[CTRL_ENABLE_BIT] = enable_q;
            REG_STATUS:  rd_data[0] = ctrl.flush_busy;
            REG_HITS:    rd_data = 32'(cnt_q[CNT_HIT]);
            REG_MISSES:  rd_data = 32'(cnt_q[CNT_MISS]);
            REG_UPDATES: rd_data = 32'(cnt_q[CNT_UPD]);
            default:     rd_data = '0;
        endcase
    end

    assign prdata  = (access && !pwrite) ? rd_data : '0;
    assign pslverr = access && !mapped;

    // ####################################################################
    // assertions
    // ####################################################################

    a_flush_pulse: assert property (@(posedge CLK) disable iff (rst)
        ctrl.flush_start |=> !ctrl.flush_start);

    // an error only shows in an access cycle that followed its setup cycle.
    a_err_in_access: assert property (@(posedge CLK) disable iff (rst)
        pslverr |-> (psel && penable && $past(psel && !penable)));

endmodule : btb_csr

`default_nettype wire

//--- logic/btb_array.sv
// two-way set-associative btb target store with LRU replacement and flush walk.
`default_nettype none

module btb_array #(
    parameter int NUM_SETS = 256
) (
    input  logic           CLK,
    input  logic           rst,
    // lookup from fetch.
    input  logic           branch,
    input  btb_pkg::addr_t pc,
    // resolved branches from execute.
    input  logic           upd_valid,
    input  btb_pkg::addr_t upd_pc,
    input  btb_pkg::addr_t upd_target,
    // registered prediction.
    output logic           pred_valid,
    output logic           pred_hit,
    output btb_pkg::addr_t pred_target,
    btb_ctrl_if.array      ctrl
);
    import btb_pkg::*;

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 30 - IDX_W;

    // ####################################################################
    // storage
    // ####################################################################

    // the flush walk clears valid and lru set by set.
    logic [1:0]       valid_mem [NUM_SETS];
    logic [TAG_W-1:0] tag_mem   [NUM_SETS][2];
    addr_t            tgt_mem   [NUM_SETS][2];
    // lru bit holds the index of the least recently used way.
    logic             lru_mem   [NUM_SETS];

    btb_state_e       state_q;
    logic [IDX_W-1:0] flush_idx_q;
    logic             active;

    logic [IDX_W-1:0] lk_idx;
    logic [TAG_W-1:0] lk_tag;
    logic [1:0]       lk_hit;
    logic             lk_any;
    logic             lk_way;
    logic             lk_sel;

    logic [IDX_W-1:0] upd_idx;
    logic [TAG_W-1:0] upd_tag;
    logic [1:0]       upd_match;
    logic             upd_way;
    logic             upd_en;

    // word index and tag with the byte offset bits dropped.
    assign lk_idx  = pc[IDX_W+1:2];
    assign lk_tag  = pc[31:IDX_W+2];
    assign upd_idx = upd_pc[IDX_W+1:2];
    assign upd_tag = upd_pc[31:IDX_W+2];

    // a flush request in this cycle already counts as flushing.
    assign active = ctrl.enable && (state_q == ST_RUN) && !ctrl.flush_start;

    // ####################################################################
    // tag compare
    // ####################################################################

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            lk_hit[w]    = valid_mem[lk_idx][w] && (tag_mem[lk_idx][w] == lk_tag);
            upd_match[w] = valid_mem[upd_idx][w] && (tag_mem[upd_idx][w] == upd_tag);
        end
    end

    assign lk_any = |lk_hit;
    assign lk_way = lk_hit[1];
    assign lk_sel = branch && active && lk_any;
    assign upd_en = upd_valid && active;

    // victim is the matching way, then free way 0, free way 1, then the lru way.
    always_comb begin
        if (upd_match[0]) begin
            upd_way = 1'b0;
        end else if (upd_match[1]) begin
            upd_way = 1'b1;
        end else if (!valid_mem[upd_idx][0]) begin
            upd_way = 1'b0;
        end else if (!valid_mem[upd_idx][1]) begin
            upd_way = 1'b1;
        end else begin
            upd_way = lru_mem[upd_idx];
        end
    end

    // ####################################################################
    // state machine
    // ####################################################################

    always_ff @(posedge CLK) begin
        if (rst) begin
            state_q     <= ST_FLUSH;
            flush_idx_q <= '0;
        end else if (ctrl.flush_start) begin
            state_q     <= ST_FLUSH;
            flush_idx_q <= '0;
        end else begin
            case (state_q)
                ST_FLUSH: begin
                    flush_idx_q <= flush_idx_q + 1'b1;
                    if (flush_idx_q == IDX_W'(NUM_SETS - 1)) begin
                        state_q <= ST_RUN;
                    end
                end
                default: begin
                    state_q <= ST_RUN;
                end
            endcase
        end
    end

    assign ctrl.flush_busy = (state_q == ST_FLUSH);

    // memory writes. update comes last so its lru change wins.
    always_ff @(posedge CLK) begin
        if (state_q == ST_FLUSH) begin
            valid_mem[flush_idx_q] <= 2'b00;
            lru_mem[flush_idx_q]   <= 1'b0;
        end else begin
            if (lk_sel) begin
                lru_mem[lk_idx] <= ~lk_way;
            end
            if (upd_en) begin
                valid_mem[upd_idx][upd_way] <= 1'b1;
                tag_mem[upd_idx][upd_way]   <= upd_tag;
                tgt_mem[upd_idx][upd_way]   <= upd_target;
                lru_mem[upd_idx]            <= ~upd_way;
            end
        end
    end

    // registered prediction and event pulses.
    always_ff @(posedge CLK) begin
        if (rst) begin
            pred_valid    <= 1'b0;
            pred_hit      <= 1'b0;
            pred_target   <= '0;
            ctrl.hit_evt  <= 1'b0;
            ctrl.miss_evt <= 1'b0;
            ctrl.upd_evt  <= 1'b0;
        end else begin
            pred_valid    <= branch;
            pred_hit      <= lk_sel;
            pred_target   <= lk_sel ? tgt_mem[lk_idx][lk_way] : '0;
            ctrl.hit_evt  <= lk_sel;
            ctrl.miss_evt <= branch && active && !lk_any;
            ctrl.upd_evt  <= upd_en;
        end
    end

    // ####################################################################
    // assertions
    // ####################################################################

    // replacement must never leave the same tag in both ways.
    a_single_way_hit: assert property (@(posedge CLK) disable iff (rst)
        (branch && state_q == ST_RUN) |-> !(&lk_hit));

    a_hit_has_valid: assert property (@(posedge CLK) disable iff (rst)
        pred_hit |-> pred_valid);

    // events must stay quiet across the whole flush walk.
    a_no_evt_in_flush: assert property (@(posedge CLK) disable iff (rst)
        (ctrl.hit_evt || ctrl.miss_evt || ctrl.upd_evt) |-> !ctrl.flush_busy);

endmodule : btb_array

`default_nettype wire

//--- logic/btb_ctrl_if.sv
// btb control link between the register block and the target array.
`default_nettype none

interface btb_ctrl_if;

    // register block side.
    logic enable;
    logic flush_start;

    // array side with single-cycle event pulses.
    logic flush_busy;
    logic hit_evt;
    logic miss_evt;
    logic upd_evt;

    modport csr (
        output enable,
        output flush_start,
        input  flush_busy,
        input  hit_evt,
        input  miss_evt,
        input  upd_evt
    );

    modport array (
        input  enable,
        input  flush_start,
        output flush_busy,
        output hit_evt,
        output miss_evt,
        output upd_evt
    );

endinterface : btb_ctrl_if

`default_nettype wire

//--- logic/btb_pkg.sv
// btb package with the shared address type, register map, array states and counter width.
`default_nettype none

package btb_pkg;

    // ####################################################################
    // basic types
    // ####################################################################

    // instruction address for both PCs and branch targets.
    typedef logic [31:0] addr_t;

    // width of the hit, miss and update statistics counters.
    localparam int CNT_W = 16;

    // ####################################################################
    // register map
    // ####################################################################

    // APB byte offsets of the register block.
    typedef enum logic [7:0] {
        REG_CTRL    = 8'h00,
        REG_STATUS  = 8'h04,
        REG_HITS    = 8'h08,
        REG_MISSES  = 8'h0C,
        REG_UPDATES = 8'h10
    } csr_reg_e;

    // control register bit positions.
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_FLUSH_BIT  = 1;
    localparam int CTRL_CLEAR_BIT  = 2;

    // ####################################################################
    // array state machine
    // ####################################################################

    // flush walks every set once; run serves lookups and updates.
    typedef enum logic {
        ST_FLUSH,
        ST_RUN
    } btb_state_e;

endpackage : btb_pkg

`default_nettype wire
